//--- scope_cfg.f
hdl/scope_bus_pkg.sv
hdl/scope_reg_pkg.sv
hdl/scope_cfg_if.sv
hdl/scope_bus_decode.sv
hdl/scope_reg_bank.sv
hdl/scope_chan_link.sv
hdl/scope_cfg_top.sv
sim/scope_cfg_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = scope_cfg_tb
FILELIST  = scope_cfg.f
OBJ_DIR   = obj_dir
PASS_MSG  = All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)" || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR)

//--- sim/scope_cfg_tb.sv
// Self-checking testbench for the scope configuration bank, run through the file list
`timescale 1ns/100ps

module scope_cfg_tb;

  localparam int N_CH    = 2;
  localparam int DW      = 14;
  localparam int N_RT    = 16;  // Random write/read pairs
  localparam int N_FIXED = 31;
  localparam int N_ACC   = N_FIXED + 2 * N_RT;
  localparam int TIMEOUT = 4 * N_ACC + 50;
  localparam int STRIDE  = scope_reg_pkg::CHAN_STRIDE;
  localparam int LW      = scope_reg_pkg::LANE_W;

  logic adc_clk_i, adc_rstn_i, sys_wen_i, sys_ren_i, sys_ack_o;
  logic [19:0] sys_addr_i;
  logic [31:0] sys_wdata_i, sys_rdata_o, adc_state_i, trg_state_i;
  logic [N_CH-1:0] arm_o, acq_rst_o, trig_sw_o, we_keep_o, new_src_o;
  logic [N_CH-1:0] dec_is_one_o, indep_mode_o;
  logic [N_CH*4-1:0] src_o;
  logic [N_CH*32-1:0] dly_o;
  logic [N_CH*17-1:0] dec_o;
  logic [N_CH*DW-1:0] tresh_o, hyst_o;

  logic [DW-1:0] tresh_sh [N_CH];  // Shadow register map
  logic [DW-1:0] hyst_sh [N_CH];
  logic [31:0]   dly_sh [N_CH];
  logic [16:0]   dec_sh [N_CH];
  logic [3:0]    src_sh [N_CH];
  logic [N_CH-1:0] keep_sh, indep_sh;

  logic            exp_ack [8];  // Expectations per cycle slot
  logic            exp_rd [8];
  logic [31:0]     exp_data [8];
  logic [N_CH-1:0] exp_arm [8], exp_rst [8], exp_trig [8], exp_nsrc [8];

  integer seed = 26;
  int cyc = 0;
  int cmp_slot, ch, pick;
  logic live = 1'b0;

  scope_cfg_top #(.N_CH(N_CH), .DW(DW)) u_scope_cfg_top (.*);

  initial begin
    adc_clk_i = 1'b0;
    forever #10 adc_clk_i = ~adc_clk_i;
  end

  always @(posedge adc_clk_i) begin
    cyc  <= cyc + 1;
    live <= adc_rstn_i;
    if (cyc >= TIMEOUT) begin
      $display("Checks failed");
      $fatal(1, "Timeout, the test sequence did not finish within %0d cycles", TIMEOUT);
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("Checks failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Expected read data from the register map rules
  function automatic logic [31:0] ref_read(input logic [19:0] addr);
    int blk;
    int ofs;
    blk = addr / STRIDE;
    ofs = addr % STRIDE;
    ref_read = '0;
    if (blk == 0 && ofs == scope_reg_pkg::OFS_CTRL) ref_read = adc_state_i;
    else if (blk == 0 && ofs == scope_reg_pkg::OFS_TRG_STATE) ref_read = trg_state_i;
    else if (blk < N_CH) begin
      case (ofs)
        scope_reg_pkg::OFS_TRESH: ref_read = 32'(tresh_sh[blk]);
        scope_reg_pkg::OFS_HYST:  ref_read = 32'(hyst_sh[blk]);
        scope_reg_pkg::OFS_DLY:   ref_read = dly_sh[blk];
        scope_reg_pkg::OFS_DEC:   ref_read = 32'(dec_sh[blk]);
        default:                  ref_read = '0;
      endcase
    end
  endfunction

  // Upper channels follow channel 0 unless it is independent
  function automatic logic [N_CH-1:0] gang_bits(input logic [N_CH-1:0] raw);
    for (int g = 0; g < N_CH; g++) gang_bits[g] = (g != 0 && !indep_sh[0]) ? raw[0] : raw[g];
  endfunction

  always @(negedge adc_clk_i) begin
    if (live) begin
      cmp_slot = cyc % 8;
      check("sys_ack_o", sys_ack_o, exp_ack[cmp_slot]);
      if (exp_rd[cmp_slot]) check("sys_rdata_o", sys_rdata_o, exp_data[cmp_slot]);
      check("arm_o", arm_o, exp_arm[cmp_slot]);
      check("acq_rst_o", acq_rst_o, exp_rst[cmp_slot]);
      check("trig_sw_o", trig_sw_o, exp_trig[cmp_slot]);
      check("new_src_o", new_src_o, exp_nsrc[cmp_slot]);
      exp_ack[cmp_slot]  = 1'b0;
      exp_rd[cmp_slot]   = 1'b0;
      exp_arm[cmp_slot]  = '0;
      exp_rst[cmp_slot]  = '0;
      exp_trig[cmp_slot] = '0;
      exp_nsrc[cmp_slot] = '0;
    end
  end

  // One-cycle bus strobe, starting on a falling edge
  task automatic issue(input logic wr, input logic [19:0] addr, input logic [31:0] data);
    int slot;
    int blk;
    int ofs;
    logic [LW-1:0] lane;
    logic [N_CH-1:0] r_arm, r_rst, r_trig, r_nsrc;
    slot = (cyc + 3) % 8;  // Acknowledge two edges after the sampling edge
    blk = addr / STRIDE;
    ofs = addr % STRIDE;
    r_arm = '0;
    r_rst = '0;
    r_trig = '0;
    r_nsrc = '0;
    if (wr && blk < N_CH) begin
      case (ofs)
        scope_reg_pkg::OFS_TRESH: tresh_sh[blk] = data[DW-1:0];
        scope_reg_pkg::OFS_HYST:  hyst_sh[blk] = data[DW-1:0];
        scope_reg_pkg::OFS_DLY:   dly_sh[blk] = data;
        scope_reg_pkg::OFS_DEC:   dec_sh[blk] = data[16:0];
        default: ;
      endcase
    end
    for (int g = 0; g < N_CH; g++) begin
      lane = data[g*LW +: LW];
      if (wr && blk == 0 && ofs == scope_reg_pkg::OFS_CTRL) begin
        r_arm[g] = lane[scope_reg_pkg::CTRL_ARM_BIT];
        r_rst[g] = lane[scope_reg_pkg::CTRL_RST_BIT];
        if (lane != 0) begin
          keep_sh[g]  = lane[scope_reg_pkg::CTRL_KEEP_BIT];
          indep_sh[g] = lane[scope_reg_pkg::CTRL_INDEP_BIT];
        end
      end
      if (wr && blk == 0 && ofs == scope_reg_pkg::OFS_TRG_SRC) begin
        r_trig[g] = (lane[3:0] == 4'd1);
        r_nsrc[g] = (lane != 0);
        if (lane != 0) src_sh[g] = lane[3:0];
      end
    end
    exp_ack[slot]  = 1'b1;
    exp_rd[slot]   = !wr;
    exp_data[slot] = ref_read(addr);
    exp_arm[slot]  = gang_bits(r_arm);
    exp_rst[slot]  = gang_bits(r_rst);
    exp_trig[slot] = gang_bits(r_trig);
    exp_nsrc[slot] = gang_bits(r_nsrc);
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
    @(negedge adc_clk_i);
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
  endtask

  // Let the pipeline empty, then compare the level outputs
  task automatic drain_and_check();
    int s;
    repeat (3) @(negedge adc_clk_i);
    for (int g = 0; g < N_CH; g++) begin
      s = (g != 0 && !indep_sh[0]) ? 0 : g;
      check($sformatf("src_o[%0d]", g), src_o[g*4 +: 4], src_sh[s]);
      check($sformatf("dly_o[%0d]", g), dly_o[g*32 +: 32], dly_sh[s]);
      check($sformatf("dec_o[%0d]", g), dec_o[g*17 +: 17], dec_sh[s]);
      check($sformatf("dec_is_one_o[%0d]", g), dec_is_one_o[g], dec_sh[s] == 17'd1);
      check($sformatf("we_keep_o[%0d]", g), we_keep_o[g], keep_sh[s]);
      check($sformatf("indep_mode_o[%0d]", g), indep_mode_o[g], indep_sh[g]);
      check($sformatf("tresh_o[%0d]", g), tresh_o[g*DW +: DW], tresh_sh[g]);
      check($sformatf("hyst_o[%0d]", g), hyst_o[g*DW +: DW], hyst_sh[g]);
    end
  endtask

  function automatic logic [7:0] setting_ofs(input int k);
    case (k)
      0:       setting_ofs = scope_reg_pkg::OFS_TRESH;
      1:       setting_ofs = scope_reg_pkg::OFS_HYST;
      2:       setting_ofs = scope_reg_pkg::OFS_DLY;
      default: setting_ofs = scope_reg_pkg::OFS_DEC;
    endcase
  endfunction

  initial begin
    adc_rstn_i  = 1'b0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    adc_state_i = $random(seed);
    trg_state_i = $random(seed);
    for (int k = 0; k < 8; k++) begin
      exp_ack[k] = 1'b0;
      exp_rd[k] = 1'b0;
      exp_arm[k] = '0;
      exp_rst[k] = '0;
      exp_trig[k] = '0;
      exp_nsrc[k] = '0;
    end
    for (int g = 0; g < N_CH; g++) begin  // Threshold sign alternates per channel
      tresh_sh[g] = (g % 2 == 0) ? DW'(5000) : DW'(-5000);
      hyst_sh[g]  = DW'(20);
      dly_sh[g]   = '0;
      dec_sh[g]   = 17'd1;
      src_sh[g]   = '0;
    end
    keep_sh  = '0;
    indep_sh = '0;
    repeat (4) @(negedge adc_clk_i);
    adc_rstn_i = 1'b1;
    drain_and_check();

    for (int g = 0; g < N_CH; g++)
      for (int k = 0; k < 4; k++) issue(1'b0, 20'(g * STRIDE) | 20'(setting_ofs(k)), '0);
    drain_and_check();

    for (int i = 0; i < N_RT; i++) begin
      ch   = i % N_CH;  // Every channel and setting, twice over
      pick = (i / N_CH) % 4;
      issue(1'b1, 20'(ch * STRIDE) | 20'(setting_ofs(pick)), $random(seed));
      issue(1'b0, 20'(ch * STRIDE) | 20'(setting_ofs(pick)), '0);
    end
    drain_and_check();

    issue(1'b0, 20'h0000c, '0);  // Unmapped and write-only words
    issue(1'b0, 20'h00030, '0);
    issue(1'b0, 20'h00208, '0);
    issue(1'b0, 20'h00104, '0);
    issue(1'b0, 20'h00004, '0);
    issue(1'b1, 20'h0000c, $random(seed));
    drain_and_check();

    issue(1'b1, 20'h00000, 32'h0000_0023);  // Channel 0 independent, arm and reset
    drain_and_check();
    issue(1'b1, 20'h00000, 32'h0000_020b);  // Ganged again, keep armed
    drain_and_check();
    issue(1'b1, 20'h00004, 32'h0000_0501);
    drain_and_check();

    issue(1'b1, 20'h00010, $random(seed));
    issue(1'b1, 20'h00110, $random(seed));
    issue(1'b1, 20'h00014, 32'd1);
    issue(1'b1, 20'h00114, 32'd7);
    issue(1'b0, 20'h00110, '0);
    issue(1'b0, 20'h00114, '0);
    drain_and_check();
    issue(1'b1, 20'h00000, 32'h0000_2020);  // Both channels independent
    drain_and_check();
    issue(1'b1, 20'h00004, 32'h0000_0103);
    drain_and_check();

    adc_state_i = $random(seed);
    trg_state_i = $random(seed);
    issue(1'b0, 20'h00000, '0);
    issue(1'b0, 20'h00024, '0);
    issue(1'b0, 20'h00108, '0);
    issue(1'b0, 20'h00014, '0);
    issue(1'b0, 20'h00120, '0);
    issue(1'b0, 20'h00020, '0);
    drain_and_check();

    $display("All checks passed");
    $finish;
  end

endmodule

//--- hdl/scope_cfg_top.sv
// Top level of the scope configuration bank, system bus in and per-channel settings out
`timescale 1ns/100ps

module scope_cfg_top #(
  parameter int N_CH = 2,
  parameter int DW   = 14
) (
  input  logic                                      adc_clk_i,
  input  logic                                      adc_rstn_i,
  input  logic [scope_bus_pkg::BUS_AW-1:0]          sys_addr_i,
  input  logic [scope_bus_pkg::BUS_DW-1:0]          sys_wdata_i,
  input  logic                                      sys_wen_i,
  input  logic                                      sys_ren_i,
  output logic [scope_bus_pkg::BUS_DW-1:0]          sys_rdata_o,
  output logic                                      sys_ack_o,
  input  logic [scope_bus_pkg::BUS_DW-1:0]          adc_state_i,
  input  logic [scope_bus_pkg::BUS_DW-1:0]          trg_state_i,
  output logic [N_CH-1:0]                           arm_o,
  output logic [N_CH-1:0]                           acq_rst_o,
  output logic [N_CH-1:0]                           trig_sw_o,
  output logic [N_CH-1:0]                           we_keep_o,
  output logic [N_CH-1:0]                           new_src_o,
  output logic [N_CH*scope_reg_pkg::SRC_W-1:0]      src_o,
  output logic [N_CH*scope_reg_pkg::DLY_W-1:0]      dly_o,
  output logic [N_CH*scope_reg_pkg::DEC_W-1:0]      dec_o,
  output logic [N_CH-1:0]                           dec_is_one_o,
  output logic [N_CH-1:0]                           indep_mode_o,
  output logic [N_CH*DW-1:0]                        tresh_o,
  output logic [N_CH*DW-1:0]                        hyst_o
);

  cfg_access_if #(.N_CH(N_CH)) u_acc_if ();
  chan_cfg_if   #(.N_CH(N_CH)) u_cfg_if ();

  scope_bus_decode #(.N_CH(N_CH)) u_scope_bus_decode (
    .adc_clk_i   (adc_clk_i),
    .adc_rstn_i  (adc_rstn_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .acc_o       (u_acc_if.decode)
  );

  scope_reg_bank #(.N_CH(N_CH), .DW(DW)) u_scope_reg_bank (
    .adc_clk_i   (adc_clk_i),
    .adc_rstn_i  (adc_rstn_i),
    .acc_i       (u_acc_if.bank),
    .adc_state_i (adc_state_i),
    .trg_state_i (trg_state_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .tresh_o     (tresh_o),
    .hyst_o      (hyst_o),
    .cfg_o       (u_cfg_if.bank)
  );

  scope_chan_link #(.N_CH(N_CH)) u_scope_chan_link (
    .cfg_i        (u_cfg_if.link),
    .arm_o        (arm_o),
    .acq_rst_o    (acq_rst_o),
    .trig_sw_o    (trig_sw_o),
    .we_keep_o    (we_keep_o),
    .new_src_o    (new_src_o),
    .src_o        (src_o),
    .dly_o        (dly_o),
    .dec_o        (dec_o),
    .dec_is_one_o (dec_is_one_o),
    .indep_mode_o (indep_mode_o)
  );

endmodule

//--- hdl/scope_chan_link.sv
// Third stage of the scope configuration bank, gangs channels to channel 0 unless independent
`timescale 1ns/100ps

module scope_chan_link #(
  parameter int N_CH = 2
) (
  chan_cfg_if.link                                cfg_i,
  output logic [N_CH-1:0]                         arm_o,
  output logic [N_CH-1:0]                         acq_rst_o,
  output logic [N_CH-1:0]                         trig_sw_o,
  output logic [N_CH-1:0]                         we_keep_o,
  output logic [N_CH-1:0]                         new_src_o,
  output logic [N_CH*scope_reg_pkg::SRC_W-1:0]    src_o,
  output logic [N_CH*scope_reg_pkg::DLY_W-1:0]    dly_o,
  output logic [N_CH*scope_reg_pkg::DEC_W-1:0]    dec_o,
  output logic [N_CH-1:0]                         dec_is_one_o,
  output logic [N_CH-1:0]                         indep_mode_o
);

  localparam int SRC_W = scope_reg_pkg::SRC_W;
  localparam int DLY_W = scope_reg_pkg::DLY_W;
  localparam int DEC_W = scope_reg_pkg::DEC_W;
  localparam logic [DEC_W-1:0] DEC_ONE = {{(DEC_W-1){1'b0}}, 1'b1};

  for (genvar g = 0; g < N_CH; g++) begin : g_ch
    logic             gang;
    logic [DEC_W-1:0] dec_g;

    assign gang = (g != 0) && !cfg_i.indep[0];  // Channel 0 mode rules all

    assign arm_o[g]     = gang ? cfg_i.arm[0]     : cfg_i.arm[g];
    assign acq_rst_o[g] = gang ? cfg_i.acq_rst[0] : cfg_i.acq_rst[g];
    assign trig_sw_o[g] = gang ? cfg_i.trig_sw[0] : cfg_i.trig_sw[g];
    assign we_keep_o[g] = gang ? cfg_i.we_keep[0] : cfg_i.we_keep[g];
    assign new_src_o[g] = gang ? cfg_i.new_src[0] : cfg_i.new_src[g];

    assign src_o[g*SRC_W +: SRC_W] = gang ? cfg_i.src[0] : cfg_i.src[g];
    assign dly_o[g*DLY_W +: DLY_W] = gang ? cfg_i.dly[0] : cfg_i.dly[g];
    assign dec_g                   = gang ? cfg_i.dec[0] : cfg_i.dec[g];
    assign dec_o[g*DEC_W +: DEC_W] = dec_g;
    assign dec_is_one_o[g]         = (dec_g == DEC_ONE);  // Decimator bypass

    assign indep_mode_o[g] = cfg_i.indep[g];
  end

endmodule

//--- hdl/scope_reg_bank.sv
// Second pipeline stage of the scope configuration bank, holds settings and answers the bus
`timescale 1ns/100ps

module scope_reg_bank #(
  parameter int N_CH = 2,
  parameter int DW   = 14
) (
  input  logic                             adc_clk_i,
  input  logic                             adc_rstn_i,
  cfg_access_if.bank                       acc_i,
  input  logic [scope_bus_pkg::BUS_DW-1:0] adc_state_i,
  input  logic [scope_bus_pkg::BUS_DW-1:0] trg_state_i,
  output logic [scope_bus_pkg::BUS_DW-1:0] sys_rdata_o,
  output logic                             sys_ack_o,
  output logic [N_CH*DW-1:0]               tresh_o,
  output logic [N_CH*DW-1:0]               hyst_o,
  chan_cfg_if.bank                         cfg_o
);

  localparam logic [DW-1:0] TRESH_POS = DW'(scope_reg_pkg::TRESH_RST);
  localparam logic [DW-1:0] TRESH_NEG = DW'(-scope_reg_pkg::TRESH_RST);
  localparam logic [DW-1:0] HYST_INIT = DW'(scope_reg_pkg::HYST_RST);
  localparam logic [scope_reg_pkg::SRC_W-1:0] SRC_SW_TRIG =
    {{(scope_reg_pkg::SRC_W-1){1'b0}}, 1'b1};

  logic [N_CH-1:0][DW-1:0]                     tresh_q;
  logic [N_CH-1:0][DW-1:0]                     hyst_q;
  logic [N_CH-1:0][scope_reg_pkg::DLY_W-1:0]   dly_q;
  logic [N_CH-1:0][scope_reg_pkg::DEC_W-1:0]   dec_q;
  logic [N_CH-1:0][scope_reg_pkg::LANE_W-1:0]  lane;
  logic                                        is_wr;
  logic                                        ctrl_wr;
  logic                                        src_wr;

  assign lane    = acc_i.wdata[N_CH*scope_reg_pkg::LANE_W-1:0];
  assign is_wr   = (acc_i.kind == scope_bus_pkg::KIND_WRITE);
  assign ctrl_wr = is_wr && (acc_i.sel == scope_reg_pkg::SEL_CTRL);
  assign src_wr  = is_wr && (acc_i.sel == scope_reg_pkg::SEL_TRG_SRC);

  // Per-channel settings
  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      for (int g = 0; g < N_CH; g++) begin
        tresh_q[g] <= (g % 2 == 0) ? TRESH_POS : TRESH_NEG;
        hyst_q[g]  <= HYST_INIT;
        dly_q[g]   <= '0;
        dec_q[g]   <= scope_reg_pkg::DEC_RST;
      end
    end else if (is_wr) begin
      case (acc_i.sel)
        scope_reg_pkg::SEL_TRESH: tresh_q[acc_i.chan] <= acc_i.wdata[DW-1:0];
        scope_reg_pkg::SEL_HYST:  hyst_q[acc_i.chan]  <= acc_i.wdata[DW-1:0];
        scope_reg_pkg::SEL_DLY:   dly_q[acc_i.chan]   <= acc_i.wdata[scope_reg_pkg::DLY_W-1:0];
        scope_reg_pkg::SEL_DEC:   dec_q[acc_i.chan]   <= acc_i.wdata[scope_reg_pkg::DEC_W-1:0];
        default: ;
      endcase
    end
  end

  // Command pulses, mode flags and acknowledge
  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      cfg_o.arm     <= '0;
      cfg_o.acq_rst <= '0;
      cfg_o.trig_sw <= '0;
      cfg_o.new_src <= '0;
      cfg_o.we_keep <= '0;
      cfg_o.indep   <= '0;
      cfg_o.src     <= '0;
      sys_ack_o     <= 1'b0;
    end else begin
      sys_ack_o <= (acc_i.kind != scope_bus_pkg::KIND_IDLE);  // Unmapped too
      for (int g = 0; g < N_CH; g++) begin
        cfg_o.arm[g]     <= ctrl_wr && lane[g][scope_reg_pkg::CTRL_ARM_BIT];
        cfg_o.acq_rst[g] <= ctrl_wr && lane[g][scope_reg_pkg::CTRL_RST_BIT];
        cfg_o.trig_sw[g] <= src_wr && (lane[g][scope_reg_pkg::SRC_W-1:0] == SRC_SW_TRIG);
        cfg_o.new_src[g] <= src_wr && (|lane[g]);
        // An all-zero lane leaves that channel alone
        if (ctrl_wr && (|lane[g])) begin
          cfg_o.we_keep[g] <= lane[g][scope_reg_pkg::CTRL_KEEP_BIT];
          cfg_o.indep[g]   <= lane[g][scope_reg_pkg::CTRL_INDEP_BIT];
        end
        if (src_wr && (|lane[g])) begin
          cfg_o.src[g] <= lane[g][scope_reg_pkg::SRC_W-1:0];
        end
      end
    end
  end

  // Read data lines up with the acknowledge
  always_ff @(posedge adc_clk_i) begin
    case (acc_i.sel)
      scope_reg_pkg::SEL_TRESH:     sys_rdata_o <= scope_bus_pkg::BUS_DW'(tresh_q[acc_i.chan]);
      scope_reg_pkg::SEL_HYST:      sys_rdata_o <= scope_bus_pkg::BUS_DW'(hyst_q[acc_i.chan]);
      scope_reg_pkg::SEL_DLY:       sys_rdata_o <= scope_bus_pkg::BUS_DW'(dly_q[acc_i.chan]);
      scope_reg_pkg::SEL_DEC:       sys_rdata_o <= scope_bus_pkg::BUS_DW'(dec_q[acc_i.chan]);
      scope_reg_pkg::SEL_ADC_STATE: sys_rdata_o <= adc_state_i;
      scope_reg_pkg::SEL_TRG_STATE: sys_rdata_o <= trg_state_i;
      default:                      sys_rdata_o <= '0;  // Trigger source reads zero
    endcase
  end

  assign tresh_o   = tresh_q;
  assign hyst_o    = hyst_q;
  assign cfg_o.dly = dly_q;
  assign cfg_o.dec = dec_q;

endmodule

//--- hdl/scope_bus_decode.sv
// First pipeline stage of the scope configuration bank, turns bus strobes into decoded accesses
`timescale 1ns/100ps

module scope_bus_decode #(
  parameter int N_CH = 2
) (
  input  logic                             adc_clk_i,
  input  logic                             adc_rstn_i,
  input  logic [scope_bus_pkg::BUS_AW-1:0] sys_addr_i,
  input  logic [scope_bus_pkg::BUS_DW-1:0] sys_wdata_i,
  input  logic                             sys_wen_i,
  input  logic                             sys_ren_i,
  cfg_access_if.decode                     acc_o
);

  localparam int CH_W  = scope_reg_pkg::chan_w(N_CH);
  localparam int OFS_W = $clog2(scope_reg_pkg::CHAN_STRIDE);

  logic                             wen_q;
  logic                             ren_q;
  logic [scope_bus_pkg::BUS_AW-1:0] addr_q;
  logic [scope_bus_pkg::BUS_DW-1:0] wdata_q;
  logic [scope_bus_pkg::BUS_AW-OFS_W-1:0] blk;
  logic [OFS_W-1:0]                 ofs;
  logic                             blk_zero;
  logic                             blk_ok;
  scope_reg_pkg::reg_sel_e          sel_d;

  // Sample the raw access
  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      wen_q <= 1'b0;
      ren_q <= 1'b0;
    end else begin
      wen_q <= sys_wen_i;
      ren_q <= sys_ren_i;
    end
    addr_q  <= sys_addr_i;
    wdata_q <= sys_wdata_i;
  end

  assign blk      = addr_q[scope_bus_pkg::BUS_AW-1:OFS_W];
  assign ofs      = addr_q[OFS_W-1:0];
  assign blk_zero = (blk == '0);
  assign blk_ok   = (blk < N_CH);  // Per-channel block exists

  always_comb begin
    sel_d = scope_reg_pkg::SEL_NONE;
    case (ofs)
      scope_reg_pkg::OFS_CTRL:      if (blk_zero) sel_d = wen_q ? scope_reg_pkg::SEL_CTRL
                                                                : scope_reg_pkg::SEL_ADC_STATE;
      scope_reg_pkg::OFS_TRG_SRC:   if (blk_zero) sel_d = scope_reg_pkg::SEL_TRG_SRC;
      scope_reg_pkg::OFS_TRG_STATE: if (blk_zero) sel_d = scope_reg_pkg::SEL_TRG_STATE;
      scope_reg_pkg::OFS_TRESH:     if (blk_ok)   sel_d = scope_reg_pkg::SEL_TRESH;
      scope_reg_pkg::OFS_DLY:       if (blk_ok)   sel_d = scope_reg_pkg::SEL_DLY;
      scope_reg_pkg::OFS_DEC:       if (blk_ok)   sel_d = scope_reg_pkg::SEL_DEC;
      scope_reg_pkg::OFS_HYST:      if (blk_ok)   sel_d = scope_reg_pkg::SEL_HYST;
      default:                      sel_d = scope_reg_pkg::SEL_NONE;
    endcase
  end

  // Decoded access, write wins over read
  always_ff @(posedge adc_clk_i) begin
    if (!adc_rstn_i) begin
      acc_o.kind <= scope_bus_pkg::KIND_IDLE;
    end else if (wen_q) begin
      acc_o.kind <= scope_bus_pkg::KIND_WRITE;
    end else if (ren_q) begin
      acc_o.kind <= scope_bus_pkg::KIND_READ;
    end else begin
      acc_o.kind <= scope_bus_pkg::KIND_IDLE;
    end
    acc_o.sel   <= sel_d;
    acc_o.chan  <= blk[CH_W-1:0];  // Zero for shared words
    acc_o.wdata <= wdata_q;
  end

endmodule

//--- hdl/scope_cfg_if.sv
// Internal links of the scope configuration pipeline: decoded bus access and per-channel settings
`timescale 1ns/100ps

interface cfg_access_if #(
  parameter int N_CH = 2
) ();

  localparam int CH_W = scope_reg_pkg::chan_w(N_CH);

  scope_bus_pkg::bus_kind_e          kind;   // Not idle for one cycle per access
  scope_reg_pkg::reg_sel_e           sel;
  logic [CH_W-1:0]                   chan;
  logic [scope_bus_pkg::BUS_DW-1:0]  wdata;

  modport decode (output kind, output sel, output chan, output wdata);
  modport bank   (input  kind, input  sel, input  chan, input  wdata);

endinterface

interface chan_cfg_if #(
  parameter int N_CH = 2
) ();

  logic [N_CH-1:0]                           arm;      // Pulses
  logic [N_CH-1:0]                           acq_rst;
  logic [N_CH-1:0]                           trig_sw;
  logic [N_CH-1:0]                           new_src;
  logic [N_CH-1:0]                           we_keep;  // Levels
  logic [N_CH-1:0]                           indep;
  logic [N_CH-1:0][scope_reg_pkg::SRC_W-1:0] src;
  logic [N_CH-1:0][scope_reg_pkg::DLY_W-1:0] dly;
  logic [N_CH-1:0][scope_reg_pkg::DEC_W-1:0] dec;

  modport bank (output arm, output acq_rst, output trig_sw, output new_src, output we_keep,
                output indep, output src, output dly, output dec);
  modport link (input  arm, input  acq_rst, input  trig_sw, input  new_src, input  we_keep,
                input  indep, input  src, input  dly, input  dec);

endinterface

//--- hdl/scope_reg_pkg.sv
// Register map of the scope configuration bank: selectors, offsets, field widths, reset values
package scope_reg_pkg;

  // Decoded register
  typedef enum logic [3:0] {
    SEL_CTRL      = 4'd0,
    SEL_TRG_SRC   = 4'd1,
    SEL_TRESH     = 4'd2,
    SEL_DLY       = 4'd3,
    SEL_DEC       = 4'd4,
    SEL_HYST      = 4'd5,
    SEL_ADC_STATE = 4'd6,
    SEL_TRG_STATE = 4'd7,
    SEL_NONE      = 4'd8
  } reg_sel_e;

  localparam int CHAN_STRIDE = 'h100;  // One block per channel

  localparam logic [7:0] OFS_CTRL      = 8'h00;  // Also adc state on read
  localparam logic [7:0] OFS_TRG_SRC   = 8'h04;
  localparam logic [7:0] OFS_TRESH     = 8'h08;
  localparam logic [7:0] OFS_DLY       = 8'h10;
  localparam logic [7:0] OFS_DEC       = 8'h14;
  localparam logic [7:0] OFS_HYST      = 8'h20;
  localparam logic [7:0] OFS_TRG_STATE = 8'h24;  // Block 0 only

  localparam int DEC_W  = 17;
  localparam int DLY_W  = 32;
  localparam int SRC_W  = 4;
  localparam int LANE_W = 8;  // Byte lane per channel in shared words

  localparam int CTRL_ARM_BIT   = 0;
  localparam int CTRL_RST_BIT   = 1;
  localparam int CTRL_KEEP_BIT  = 3;
  localparam int CTRL_INDEP_BIT = 5;

  localparam int               TRESH_RST = 5000;  // Negated on odd channels
  localparam int               HYST_RST  = 20;
  localparam logic [DEC_W-1:0] DEC_RST   = 17'd1;

  // Width of a channel index, at least one bit
  function automatic int chan_w(input int n_ch);
    return (n_ch > 1) ? $clog2(n_ch) : 1;
  endfunction

endpackage

//--- hdl/scope_bus_pkg.sv
// System bus widths and access kinds, shared by the scope configuration bank and its testbench
package scope_bus_pkg;

  localparam int BUS_AW = 20;  // Byte address seen by the bank
  localparam int BUS_DW = 32;

  // Kind of access carried through the pipeline
  typedef enum logic [1:0] {
    KIND_IDLE  = 2'd0,
    KIND_WRITE = 2'd1,
    KIND_READ  = 2'd2
  } bus_kind_e;

endpackage
